// File: tb.f
+incdir+.
cacheGeomPkg.sv
m68kBusPkg.sv
cacheLookupIf.sv
cacheSequencer.sv
cacheTagStore.sv
cacheDataStore.sv
m68kCacheTop.sv
m68kCache_chk.sv
tb_m68kCache.sv

// File: Bender.yml
package:
  name: m68k_cache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cacheGeomPkg.sv
      - m68kBusPkg.sv
      - cacheLookupIf.sv
      - cacheSequencer.sv
      - cacheTagStore.sv
      - cacheDataStore.sv
      - m68kCacheTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - m68kCache_chk.sv
      - tb_m68kCache.sv

// File: tb_m68kCache.sv
// testbench for the 68k read cache
// drives CPU bus cycles and models the DRAM controller with bursts, refresh and write acks
module tb_m68kCache;

	// 48 transactions of at most about 30 clocks each plus the sweep, with margin
	localparam int cycleLimit = 3000;

	logic Clock;
	logic Reset_L;
	logic AS_L;
	logic UDS_L;
	logic LDS_L;
	logic WE_L;
	logic DramSelect;
	m68kBusPkg::busAddr CpuAddr;
	m68kBusPkg::busWord CpuDataIn;
	m68kBusPkg::busWord CpuDataOut;
	logic DtackToCpu_L;
	logic DramSel_L;
	logic DramAS_L;
	logic DramUDS_L;
	logic DramLDS_L;
	logic DramWE_L;
	m68kBusPkg::busAddr DramAddr;
	m68kBusPkg::busWord DramDataOut;
	m68kBusPkg::busWord DramDataIn;
	logic DramDtack_L;
	logic CAS_Dram_L;
	logic RAS_Dram_L;

	int cycleCount = 0;

	// number of line fills the DRAM model has answered so far
	int fillsServed = 0;

	// lines 0 and 1 share index 4 with different tags, so they evict each other
	m68kBusPkg::busAddr lineBase [4] = '{32'h0000_0040, 32'h0001_0040, 32'h0000_0120,
		32'h00ab_c3f0};

	m68kCacheTop dut0 (.*);

	bind m68kCacheTop m68kCache_chk chk0 (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.AS_L(AS_L),
		.UDS_L(UDS_L),
		.LDS_L(LDS_L),
		.WE_L(WE_L),
		.DramSelect(DramSelect),
		.CpuAddr(CpuAddr),
		.CpuDataIn(CpuDataIn),
		.CpuDataOut(CpuDataOut),
		.DtackToCpu_L(DtackToCpu_L),
		.DramSel_L(DramSel_L),
		.DramAS_L(DramAS_L),
		.DramUDS_L(DramUDS_L),
		.DramLDS_L(DramLDS_L),
		.DramWE_L(DramWE_L),
		.DramAddr(DramAddr),
		.DramDataOut(DramDataOut),
		.DramDtack_L(DramDtack_L),
		.CAS_Dram_L(CAS_Dram_L),
		.RAS_Dram_L(RAS_Dram_L),
		.state(seq0.state)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	task automatic stopOnFailure(input string why);
		$display(">>> FAIL");
		$fatal(1, why);
	endtask

	// inputs change a fixed 5 units after the rising edge
	task automatic tick();
		@(posedge Clock);
		#5;
	endtask

	// data the DRAM holds at a given word address
	function automatic m68kBusPkg::busWord dramWord(input m68kBusPkg::busAddr wordAddr);
		return wordAddr[15:0] ^ 16'hA5C3;
	endfunction

	////////////////////
	// CPU bus cycles
	////////////////////

	// the cycle ends by lifting AS_L or, now and then, by dropping DramSelect
	task automatic endCycle(input logic viaSelect);
		if (viaSelect)
			DramSelect = 1'b0;
		else
			AS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		do
			@(negedge Clock);
		while (!DtackToCpu_L);
		tick();
		AS_L = 1'b1;
		tick();
		DramSelect = 1'b1;
	endtask

	task automatic runCycle(input m68kBusPkg::busAddr addr, input logic isWrite,
		input m68kBusPkg::busWord data, input logic viaSelect);
		int unsigned strobes;
		strobes = $urandom % 3;
		CpuAddr = addr;
		CpuDataIn = data;
		WE_L = !isWrite;
		UDS_L = (strobes == 2);
		LDS_L = (strobes == 1);
		DramSelect = 1'b1;
		AS_L = 1'b0;
		do
			@(negedge Clock);
		while (DtackToCpu_L);
		tick();
		endCycle(viaSelect);
	endtask

	////////////////////
	// DRAM controller model
	////////////////////

	task automatic serveFill(input m68kBusPkg::busAddr base);
		int unsigned delay;
		delay = 3 + ($urandom % 3);
		repeat (delay) tick();
		// the first fill always sees a refresh pulse first, later ones about one in four
		if (fillsServed == 0 || $urandom % 4 == 0) begin
			CAS_Dram_L = 1'b0;
			RAS_Dram_L = 1'b0;
			tick();
			CAS_Dram_L = 1'b1;
			RAS_Dram_L = 1'b1;
			tick();
		end
		CAS_Dram_L = 1'b0;
		tick();
		CAS_Dram_L = 1'b1;
		tick();
		tick();
		for (int k = 0; k < 8; k++) begin
			DramDataIn = dramWord((base >> 1) + m68kBusPkg::busAddr'(k));
			tick();
		end
		fillsServed++;
	endtask

	task automatic ackWrite();
		tick();
		tick();
		DramDtack_L = 1'b0;
		do
			@(negedge Clock);
		while (!DramSel_L);
		tick();
		DramDtack_L = 1'b1;
	endtask

	initial begin
		forever begin
			@(negedge Clock);
			if (DramSel_L === 1'b0) begin
				if (DramWE_L)
					serveFill(DramAddr);
				else
					ackWrite();
			end
		end
	end

	////////////////////
	// run control
	////////////////////

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
			stopOnFailure("timeout: run did not finish within the cycle limit");
	end

	always @(negedge Clock) begin
		if (dut0.chk0.errorCount != 0)
			stopOnFailure("a bus rule assertion failed");
	end

	initial begin
		m68kBusPkg::busAddr addr;
		logic viaSelect;
		void'($urandom(81));
		Reset_L = 1'b0;
		AS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		WE_L = 1'b1;
		DramSelect = 1'b0;
		CpuAddr = '0;
		CpuDataIn = '0;
		DramDataIn = '0;
		DramDtack_L = 1'b1;
		CAS_Dram_L = 1'b1;
		RAS_Dram_L = 1'b1;
		repeat (16) @(posedge Clock);
		#5;
		Reset_L = 1'b1;

		// first read is raised while the sweep is still running
		runCycle(lineBase[0] | 32'h6, 1'b0, 16'h0, 1'b0);
		runCycle(lineBase[0] | 32'ha, 1'b0, 16'h0, 1'b0);
		runCycle(lineBase[1] | 32'h2, 1'b0, 16'h0, 1'b1);
		runCycle(lineBase[0], 1'b0, 16'h0, 1'b0);
		runCycle(lineBase[0] | 32'h4, 1'b1, 16'h1234, 1'b0);
		runCycle(lineBase[0] | 32'h4, 1'b0, 16'h0, 1'b0);
		runCycle(lineBase[2] | 32'he, 1'b0, 16'h0, 1'b0);
		runCycle(lineBase[2] | 32'h8, 1'b0, 16'h0, 1'b1);

		for (int i = 0; i < 40; i++) begin
			addr = lineBase[$urandom % 4] | m68kBusPkg::busAddr'(($urandom % 8) << 1);
			viaSelect = ($urandom % 5) == 0;
			runCycle(addr, ($urandom % 10) < 3, 16'($urandom), viaSelect);
		end

		tick();
		tick();
		if (dut0.chk0.errorCount == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			stopOnFailure("a bus rule assertion failed");
		end
	end

endmodule

// File: m68kCache_chk.sv
// bus rule assertions for the 68k read cache
// bound into the cache top level, keeps a small model of which lines hold a filled copy
`include "cache_macros.svh"

module m68kCache_chk (
	input logic Clock,
	input logic Reset_L,
	input logic AS_L,
	input logic UDS_L,
	input logic LDS_L,
	input logic WE_L,
	input logic DramSelect,
	input m68kBusPkg::busAddr CpuAddr,
	input m68kBusPkg::busWord CpuDataIn,
	input m68kBusPkg::busWord CpuDataOut,
	input logic DtackToCpu_L,
	input logic DramSel_L,
	input logic DramAS_L,
	input logic DramUDS_L,
	input logic DramLDS_L,
	input logic DramWE_L,
	input m68kBusPkg::busAddr DramAddr,
	input m68kBusPkg::busWord DramDataOut,
	input logic DramDtack_L,
	input logic CAS_Dram_L,
	input logic RAS_Dram_L,
	input cacheGeomPkg::seqState state
);

	// read by the testbench to stop the run at the first failed assertion
	int errorCount = 0;

	// clocks since reset was released, saturating well past the sweep
	int sinceReset;

	// a line counts as cached from its fill until the next write to its index
	logic modelValid [`CACHE_LINES];
	cacheGeomPkg::tagValue modelTag [`CACHE_LINES];

	// set from the clock a hit is taken until the CPU ends that cycle
	logic hitPending;

	cacheGeomPkg::addrFields cpuFields;
	logic readReq;
	logic expectHit;

	assign cpuFields = cacheGeomPkg::addrFields'(CpuAddr);
	assign readReq = !AS_L && DramSelect && WE_L;
	assign expectHit = modelValid[cpuFields.index] && (modelTag[cpuFields.index] == cpuFields.tag);

	// every DRAM word is the low half of its word address folded with a fixed mask
	function automatic m68kBusPkg::busWord expectedWord(input m68kBusPkg::busAddr byteAddr);
		return byteAddr[16:1] ^ 16'hA5C3;
	endfunction

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			sinceReset <= 0;
			hitPending <= 1'b0;
			for (int i = 0; i < `CACHE_LINES; i++)
				modelValid[i] <= 1'b0;
		end else begin
			if (sinceReset < 40)
				sinceReset <= sinceReset + 1;
			if (state == cacheGeomPkg::stIdle && readReq && expectHit)
				hitPending <= 1'b1;
			else if (AS_L || !DramSelect)
				hitPending <= 1'b0;
			if (state == cacheGeomPkg::stFillDone) begin
				modelValid[cpuFields.index] <= 1'b1;
				modelTag[cpuFields.index] <= cpuFields.tag;
			end
			if (state == cacheGeomPkg::stWriteThru)
				modelValid[cpuFields.index] <= 1'b0;
		end
	end

	////////////////////
	// reset and reads
	////////////////////

	// one reset clock plus 32 line clears with the bus quiet
	sweepQuiet: assert property (@(posedge Clock) disable iff (!Reset_L)
		(sinceReset < 33) |-> (DtackToCpu_L && DramSel_L))
	else begin
		$error("CHECK FAILED DtackToCpu_L=%h DramSel_L=%h in sweep, expected 1 and 1",
			$sampled(DtackToCpu_L), $sampled(DramSel_L));
		errorCount++;
	end

	readData: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DtackToCpu_L && WE_L) |-> (CpuDataOut == expectedWord(CpuAddr)))
	else begin
		$error("CHECK FAILED CpuDataOut got %h expected %h at CpuAddr %h",
			$sampled(CpuDataOut), expectedWord($sampled(CpuAddr)), $sampled(CpuAddr));
		errorCount++;
	end

	// a hit acknowledges in lookup, the clock after idle took the request
	hitDtack: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == cacheGeomPkg::stIdle && readReq && expectHit) |=>
		(!DtackToCpu_L && DramSel_L))
	else begin
		$error("CHECK FAILED DtackToCpu_L=%h DramSel_L=%h on a hit, expected 0 and 1",
			$sampled(DtackToCpu_L), $sampled(DramSel_L));
		errorCount++;
	end

	hitQuiet: assert property (@(posedge Clock) disable iff (!Reset_L)
		hitPending |-> DramSel_L)
	else begin
		$error("CHECK FAILED DramSel_L=%h during a hit, expected 1", $sampled(DramSel_L));
		errorCount++;
	end

	missFill: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == cacheGeomPkg::stIdle && readReq && !expectHit) |=>
		(!DramSel_L && DtackToCpu_L))
	else begin
		$error("CHECK FAILED DramSel_L=%h DtackToCpu_L=%h on a miss, expected 0 and 1",
			$sampled(DramSel_L), $sampled(DtackToCpu_L));
		errorCount++;
	end

	////////////////////
	// fills
	////////////////////

	fillAddr: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSel_L && WE_L) |-> (DramAddr[3:0] == 4'h0))
	else begin
		$error("CHECK FAILED DramAddr got %h expected low nibble 0", $sampled(DramAddr));
		errorCount++;
	end

	fillStrobes: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSel_L && WE_L) |-> (!DramUDS_L && !DramLDS_L && DramWE_L))
	else begin
		$error("CHECK FAILED DramUDS_L=%h DramLDS_L=%h DramWE_L=%h on a fill, expected 0 0 1",
			$sampled(DramUDS_L), $sampled(DramLDS_L), $sampled(DramWE_L));
		errorCount++;
	end

	// refresh pulls RAS low along with CAS and must not start the burst
	refreshIgnored: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == cacheGeomPkg::stFillReq && !CAS_Dram_L && !RAS_Dram_L) |=>
		(state == cacheGeomPkg::stFillReq))
	else begin
		$error("refresh cycle on the DRAM side moved the cache out of its fill request");
		errorCount++;
	end

	////////////////////
	// write through
	////////////////////

	writeAddr: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSel_L && !WE_L) |-> (DramAddr == CpuAddr))
	else begin
		$error("CHECK FAILED DramAddr got %h expected %h", $sampled(DramAddr), $sampled(CpuAddr));
		errorCount++;
	end

	writeData: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSel_L && !WE_L) |-> (DramDataOut == CpuDataIn && DramWE_L == WE_L))
	else begin
		$error("CHECK FAILED DramDataOut got %h expected %h DramWE_L got %h expected %h",
			$sampled(DramDataOut), $sampled(CpuDataIn), $sampled(DramWE_L), $sampled(WE_L));
		errorCount++;
	end

	// the CPU strobes reach DRAM unchanged on a write
	writeStrobes: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSel_L && !WE_L) |->
		(DramAS_L == AS_L && DramUDS_L == UDS_L && DramLDS_L == LDS_L))
	else begin
		$error("CHECK FAILED DramAS_L=%h DramUDS_L=%h DramLDS_L=%h expected %h %h %h",
			$sampled(DramAS_L), $sampled(DramUDS_L), $sampled(DramLDS_L),
			$sampled(AS_L), $sampled(UDS_L), $sampled(LDS_L));
		errorCount++;
	end

	writeDtack: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSel_L && !WE_L) |-> (DtackToCpu_L == DramDtack_L))
	else begin
		$error("CHECK FAILED DtackToCpu_L got %h expected %h",
			$sampled(DtackToCpu_L), $sampled(DramDtack_L));
		errorCount++;
	end

endmodule

// File: m68kCacheTop.sv
// direct mapped read cache between a 68k CPU bus and a DRAM controller
// joins the control FSM with the tag and data stores
module m68kCacheTop (
	input logic Clock,
	input logic Reset_L,

	// CPU side
	input logic AS_L,
	input logic UDS_L,
	input logic LDS_L,
	input logic WE_L,
	input logic DramSelect,
	input m68kBusPkg::busAddr CpuAddr,
	input m68kBusPkg::busWord CpuDataIn,
	output m68kBusPkg::busWord CpuDataOut,
	output logic DtackToCpu_L,

	// DRAM controller side
	output logic DramSel_L,
	output logic DramAS_L,
	output logic DramUDS_L,
	output logic DramLDS_L,
	output logic DramWE_L,
	output m68kBusPkg::busAddr DramAddr,
	output m68kBusPkg::busWord DramDataOut,
	input m68kBusPkg::busWord DramDataIn,
	input logic DramDtack_L,
	input logic CAS_Dram_L,
	input logic RAS_Dram_L
);

	cacheLookupIf lookup0 ();

	cacheGeomPkg::tagValue writeTag;

	// write data is never cached so it goes to DRAM untouched
	assign DramDataOut = CpuDataIn;

	cacheSequencer seq0 (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.AS_L(AS_L),
		.UDS_L(UDS_L),
		.LDS_L(LDS_L),
		.WE_L(WE_L),
		.DramSelect(DramSelect),
		.CpuAddr(CpuAddr),
		.DramDtack_L(DramDtack_L),
		.CAS_Dram_L(CAS_Dram_L),
		.RAS_Dram_L(RAS_Dram_L),
		.DtackToCpu_L(DtackToCpu_L),
		.DramSel_L(DramSel_L),
		.DramAS_L(DramAS_L),
		.DramUDS_L(DramUDS_L),
		.DramLDS_L(DramLDS_L),
		.DramWE_L(DramWE_L),
		.DramAddr(DramAddr),
		.WriteTag(writeTag),
		.lookup(lookup0.sequencer)
	);

	cacheTagStore tags0 (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.CpuAddr(CpuAddr),
		.WriteTag(writeTag),
		.lookup(lookup0.tagStore)
	);

	cacheDataStore data0 (
		.Clock(Clock),
		.DramDataIn(DramDataIn),
		.CpuDataOut(CpuDataOut),
		.lookup(lookup0.dataStore)
	);

endmodule

// File: cacheDataStore.sv
// line data array of the 68k read cache
// takes burst words from DRAM and reads the selected word toward the CPU
`include "cache_macros.svh"

module cacheDataStore (
	input logic Clock,
	input m68kBusPkg::busWord DramDataIn,
	output m68kBusPkg::busWord CpuDataOut,
	cacheLookupIf.dataStore lookup
);

	// eight words per line, addressed by line index then word select
	m68kBusPkg::busWord lineMem [`CACHE_LINES][`CACHE_BURST_LEN];

	////////////////////
	// burst write
	////////////////////

	// one DRAM word is captured per clock while the sequencer fills
	always_ff @(posedge Clock) begin
		if (lookup.dataWrite)
			lineMem[lookup.index][lookup.wordSel] <= DramDataIn;
	end

	////////////////////
	// word read
	////////////////////

	// the read is asynchronous so the word is ready in the same clock as DTACK
	assign CpuDataOut = lineMem[lookup.index][lookup.wordSel];

endmodule

// File: cacheTagStore.sv
// tag and valid arrays of the 68k read cache
// registers the entry of the presented line and compares it with the CPU tag
`include "cache_macros.svh"

module cacheTagStore (
	input logic Clock,
	input logic Reset_L,
	input m68kBusPkg::busAddr CpuAddr,
	input cacheGeomPkg::tagValue WriteTag,
	cacheLookupIf.tagStore lookup
);

	cacheGeomPkg::tagValue tagMem [`CACHE_LINES];
	logic validMem [`CACHE_LINES];

	// entry of the line presented on the previous clock
	cacheGeomPkg::tagValue tagQ;
	logic validQ;

	cacheGeomPkg::addrFields cpuFields;

	assign cpuFields = cacheGeomPkg::addrFields'(CpuAddr);

	////////////////////
	// array writes and registered read
	////////////////////

	// a write and a read of the same line in one clock return the old entry
	always_ff @(posedge Clock) begin
		if (lookup.tagWrite)
			tagMem[lookup.index] <= WriteTag;
		if (lookup.validWrite)
			validMem[lookup.index] <= lookup.validValue;
		tagQ <= tagMem[lookup.index];
	end

	// the arrays are only trusted once the sweep has cleared every valid bit
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			validQ <= 1'b0;
		else
			validQ <= validMem[lookup.index];
	end

	////////////////////
	// hit compare
	////////////////////

	// the CPU holds its address for the whole cycle so the live tag is safe here
	assign lookup.hit = validQ && (tagQ == cpuFields.tag);
	assign lookup.lineValid = validQ;

endmodule

// File: cacheSequencer.sv
// control FSM of the 68k read cache
// serves one CPU bus cycle at a time, sweeping valid bits after reset and burst filling on a miss
`include "cache_macros.svh"

module cacheSequencer (
	input logic Clock,
	input logic Reset_L,
	input logic AS_L,
	input logic UDS_L,
	input logic LDS_L,
	input logic WE_L,
	input logic DramSelect,
	input m68kBusPkg::busAddr CpuAddr,
	input logic DramDtack_L,
	input logic CAS_Dram_L,
	input logic RAS_Dram_L,
	output logic DtackToCpu_L,
	output logic DramSel_L,
	output logic DramAS_L,
	output logic DramUDS_L,
	output logic DramLDS_L,
	output logic DramWE_L,
	output m68kBusPkg::busAddr DramAddr,
	output cacheGeomPkg::tagValue WriteTag,
	cacheLookupIf.sequencer lookup
);

	cacheGeomPkg::seqState state;
	cacheGeomPkg::seqState nextState;

	// one counter serves both the line sweep and the burst word count
	cacheGeomPkg::lineIndex count;
	logic countClear;

	cacheGeomPkg::addrFields cpuFields;
	cacheGeomPkg::addrFields fillFields;
	cacheGeomPkg::wordSel burstWord;
	m68kBusPkg::accessKind cpuKind;
	logic cycleEnd;
	logic readCas;

	assign cpuFields = cacheGeomPkg::addrFields'(CpuAddr);
	assign cpuKind = m68kBusPkg::accessKind'(WE_L);
	assign burstWord = count[`CACHE_WORD_BITS-1:0];

	// the CPU ends its cycle by lifting AS_L or by leaving the DRAM range
	assign cycleEnd = AS_L || !DramSelect;

	// refresh also pulls CAS low, but only a read has RAS high with it
	assign readCas = !CAS_Dram_L && RAS_Dram_L;

	// fills always start at word 0 of the line
	always_comb begin
		fillFields = cpuFields;
		fillFields.word = '0;
		fillFields.byteSel = 1'b0;
	end

	////////////////////
	// state and counter
	////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= cacheGeomPkg::stReset;
			count <= '0;
		end else begin
			state <= nextState;
			if (countClear)
				count <= '0;
			else
				count <= count + cacheGeomPkg::lineIndex'(1);
		end
	end

	// address side toward DRAM and the tag to store
	// writes go out at the exact CPU address, fills at the line base
	assign DramAddr = (state == cacheGeomPkg::stWriteThru) ? CpuAddr :
		m68kBusPkg::busAddr'(fillFields);
	assign DramAS_L = AS_L;
	assign DramWE_L = WE_L;
	assign WriteTag = cpuFields.tag;

	////////////////////
	// next state and outputs
	////////////////////

	always_comb begin
		nextState = state;
		countClear = 1'b0;
		DtackToCpu_L = 1'b1;
		DramSel_L = 1'b1;

		// reads fetch the whole word whatever byte the CPU asked for
		DramUDS_L = 1'b0;
		DramLDS_L = 1'b0;

		lookup.index = cpuFields.index;
		lookup.wordSel = cpuFields.word;
		lookup.tagWrite = 1'b0;
		lookup.validWrite = 1'b0;
		lookup.validValue = 1'b0;
		lookup.dataWrite = 1'b0;

		case (state)
			cacheGeomPkg::stReset: begin
				countClear = 1'b1;
				nextState = cacheGeomPkg::stSweep;
			end

			// clear one valid bit per clock, the counter walks the lines
			cacheGeomPkg::stSweep: begin
				lookup.index = count;
				lookup.validWrite = 1'b1;
				if (count == cacheGeomPkg::lineIndex'(`CACHE_LINES - 1))
					nextState = cacheGeomPkg::stIdle;
			end

			cacheGeomPkg::stIdle: begin
				DramUDS_L = UDS_L;
				DramLDS_L = LDS_L;
				// the tag store registers this index at the same edge
				if (!AS_L && DramSelect) begin
					if (cpuKind == m68kBusPkg::accRead)
						nextState = cacheGeomPkg::stLookup;
					else
						nextState = cacheGeomPkg::stWriteThru;
				end
			end

			cacheGeomPkg::stLookup: begin
				if (lookup.hit) begin
					DtackToCpu_L = 1'b0;
					nextState = cacheGeomPkg::stHitHold;
				end else begin
					// kick the DRAM controller early so the miss costs one clock less
					DramSel_L = 1'b0;
					nextState = cacheGeomPkg::stFillReq;
				end
			end

			// hold DTACK until the CPU lets go of the cycle
			cacheGeomPkg::stHitHold: begin
				DtackToCpu_L = 1'b0;
				if (cycleEnd)
					nextState = cacheGeomPkg::stIdle;
			end

			// wait here as long as the DRAM controller withholds a read CAS
			cacheGeomPkg::stFillReq: begin
				DramSel_L = 1'b0;
				if (readCas)
					nextState = cacheGeomPkg::stCasWait1;
			end

			cacheGeomPkg::stCasWait1: begin
				DramSel_L = 1'b0;
				nextState = cacheGeomPkg::stCasWait2;
			end

			// first burst word arrives in the clock after this one
			cacheGeomPkg::stCasWait2: begin
				DramSel_L = 1'b0;
				countClear = 1'b1;
				nextState = cacheGeomPkg::stBurstFill;
			end

			// one DRAM word per clock into the word the counter selects
			cacheGeomPkg::stBurstFill: begin
				DramSel_L = 1'b0;
				lookup.wordSel = burstWord;
				lookup.dataWrite = 1'b1;
				if (burstWord == cacheGeomPkg::wordSel'(`CACHE_BURST_LEN - 1))
					nextState = cacheGeomPkg::stFillDone;
			end

			// line is complete, so mark it valid and serve the CPU word from it
			cacheGeomPkg::stFillDone: begin
				DtackToCpu_L = 1'b0;
				lookup.tagWrite = 1'b1;
				lookup.validWrite = 1'b1;
				lookup.validValue = 1'b1;
				if (cycleEnd)
					nextState = cacheGeomPkg::stIdle;
			end

			// writes bypass the cache and DTACK comes straight from DRAM
			cacheGeomPkg::stWriteThru: begin
				DramSel_L = 1'b0;
				DramUDS_L = UDS_L;
				DramLDS_L = LDS_L;
				DtackToCpu_L = DramDtack_L;
				// drop a valid copy so the next read refetches the new data
				if (lookup.lineValid)
					lookup.validWrite = 1'b1;
				if (cycleEnd)
					nextState = cacheGeomPkg::stIdle;
			end

			default: nextState = cacheGeomPkg::stReset;
		endcase
	end

endmodule

// File: cacheLookupIf.sv
// lookup and write controls between the cache sequencer and its two stores
// the sequencer drives the select and write strobes, the tag store answers with hit
interface cacheLookupIf;

	// line and word select presented to both stores
	cacheGeomPkg::lineIndex index;
	cacheGeomPkg::wordSel wordSel;

	// write strobes, each acts on the next rising clock
	logic tagWrite;
	logic validWrite;
	logic validValue;
	logic dataWrite;

	// lookup result, valid one clock after the index was presented
	logic hit;
	logic lineValid;

	modport sequencer (
		output index, wordSel, tagWrite, validWrite, validValue, dataWrite,
		input hit, lineValid
	);

	modport tagStore (
		input index, tagWrite, validWrite, validValue,
		output hit, lineValid
	);

	modport dataStore (
		input index, wordSel, dataWrite
	);

endinterface

// File: m68kBusPkg.sv
// 68k and DRAM controller bus types
// covers the address and data words and the kind of a bus cycle
`include "cache_macros.svh"

package m68kBusPkg;

	// full byte address as driven by the CPU and passed on to DRAM
	typedef logic [`CACHE_ADDR_BITS-1:0] busAddr;

	// one 16 bit data word, upper byte on UDS and lower byte on LDS
	typedef logic [`CACHE_DATA_BITS-1:0] busWord;

	// the values follow WE_L directly so a cast of the pin gives the kind
	// a high WE_L is a read and a low WE_L a write
	typedef enum logic {
		accWrite = 1'b0,
		accRead = 1'b1
	} accessKind;

endpackage

// File: cacheGeomPkg.sv
// cache geometry types for the 68k read cache
// holds the line and word selects, the address split and the sequencer states
`include "cache_macros.svh"

package cacheGeomPkg;

	////////////////////
	// address pieces
	////////////////////

	typedef logic [`CACHE_INDEX_BITS-1:0] lineIndex;
	typedef logic [`CACHE_WORD_BITS-1:0] wordSel;
	typedef logic [`CACHE_TAG_BITS-1:0] tagValue;

	// the CPU byte address read from the top bit down
	// a line is 16 bytes so word and byte bit together cover the low four bits
	typedef struct packed {
		tagValue tag;
		lineIndex index;
		wordSel word;
		logic byteSel;
	} addrFields;

	////////////////////
	// sequencer states
	////////////////////

	// the two CAS wait states cover the DRAM CAS latency
	typedef enum logic [3:0] {
		stReset = 4'd0,
		stSweep = 4'd1,
		stIdle = 4'd2,
		stLookup = 4'd3,
		stFillReq = 4'd4,
		stCasWait1 = 4'd5,
		stCasWait2 = 4'd6,
		stBurstFill = 4'd7,
		stFillDone = 4'd8,
		stWriteThru = 4'd9,
		stHitHold = 4'd10
	} seqState;

endpackage

// File: cache_macros.svh
// cache geometry and bus width macros for the 68k read cache
// shared by the packages and by modules that size their arrays
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// width of the CPU address bus in bits
`define CACHE_ADDR_BITS 32

// width of one bus word on both the CPU and the DRAM side
`define CACHE_DATA_BITS 16

// the index picks one of the lines
`define CACHE_INDEX_BITS 5

// word select within a line of eight words
`define CACHE_WORD_BITS 3

// what remains of the address above the index and word fields
`define CACHE_TAG_BITS 23

`define CACHE_LINES 32
`define CACHE_BURST_LEN 8

// clocks between the read CAS and the first burst word from DRAM
`define CACHE_CAS_LATENCY 2

`endif
